/* logic/alu.sv */
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o,
    output logic            equal_o
);

    logic less_signed;

    assign less_signed = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_SLT: result_o = {{(XLEN-1){1'b0}}, less_signed};
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_AND: result_o = a_i & b_i;
            // lui passes the upper immediate straight through
            ALU_PASS_B: result_o = b_i;
            default: result_o = a_i + b_i;
        endcase
    end

    // branch compare, independent of the selected operation
    assign equal_o = (a_i == b_i);

endmodule

/* logic/core_pkg.sv */
package core_pkg;

    // word and register index sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // sequential pc step, one instruction word
    localparam logic [XLEN-1:0] PC_STEP = 4;

    // base opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 values, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_FETCH, ST_EXEC, ST_MEM_REQ, ST_MEM_RESP
    } core_state_e;

endpackage

/* logic/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    output logic            imem_req_valid_o,
    output logic [XLEN-1:0] imem_req_addr_o,
    input  logic            imem_req_ready_i,
    input  logic            imem_resp_valid_i,
    input  logic [XLEN-1:0] imem_resp_data_i,
    output logic            imem_resp_ready_o,
    output logic            dmem_req_valid_o,
    output logic [XLEN-1:0] dmem_req_addr_o,
    output logic [XLEN-1:0] dmem_req_wdata_o,
    output logic            dmem_req_write_o,
    input  logic            dmem_req_ready_i,
    input  logic            dmem_resp_valid_i,
    input  logic [XLEN-1:0] dmem_resp_data_i,
    output logic            dmem_resp_ready_o
);

    logic                  instr_valid;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       pc;
    logic                  next_pc_valid;
    logic [XLEN-1:0]       next_pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  reg_write;
    logic                  is_branch;
    logic                  branch_ne;
    logic                  is_jal;
    logic                  is_load;
    logic                  is_store;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_result;
    logic                  alu_equal;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_rd;
    logic [XLEN-1:0]       rf_wdata;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk_i, .rstn_i,
        .imem_req_valid_o, .imem_req_addr_o, .imem_req_ready_i,
        .imem_resp_valid_i, .imem_resp_data_i, .imem_resp_ready_o,
        .next_pc_valid_i (next_pc_valid), .next_pc_i (next_pc),
        .instr_valid_o (instr_valid), .instr_o (instr), .pc_o (pc)
    );

    decoder u_decoder (
        .instr_i (instr), .rs1_o (rs1), .rs2_o (rs2), .rd_o (rd), .imm_o (imm),
        .alu_op_o (alu_op), .use_imm_o (use_imm), .reg_write_o (reg_write),
        .is_branch_o (is_branch), .branch_ne_o (branch_ne), .is_jal_o (is_jal),
        .is_load_o (is_load), .is_store_o (is_store)
    );

    register_file u_regs (
        .clk_i, .rstn_i, .rs1_i (rs1), .rs2_i (rs2), .rd_i (rf_rd), .we_i (rf_we),
        .wdata_i (rf_wdata), .rs1_data_o (rs1_data), .rs2_data_o (rs2_data)
    );

    // second alu operand: immediate or rs2
    assign alu_b = use_imm ? imm : rs2_data;

    alu u_alu (
        .op_i (alu_op), .a_i (rs1_data), .b_i (alu_b),
        .result_o (alu_result), .equal_o (alu_equal)
    );

    execute_unit u_exec (
        .clk_i, .rstn_i, .instr_valid_i (instr_valid), .pc_i (pc),
        .reg_write_i (reg_write), .is_branch_i (is_branch), .branch_ne_i (branch_ne),
        .is_jal_i (is_jal), .is_load_i (is_load), .is_store_i (is_store),
        .rd_i (rd), .imm_i (imm), .rs2_data_i (rs2_data),
        .alu_result_i (alu_result), .alu_equal_i (alu_equal),
        .dmem_req_valid_o, .dmem_req_addr_o, .dmem_req_wdata_o, .dmem_req_write_o,
        .dmem_req_ready_i, .dmem_resp_valid_i, .dmem_resp_data_i, .dmem_resp_ready_o,
        .rf_we_o (rf_we), .rf_rd_o (rf_rd), .rf_wdata_o (rf_wdata),
        .next_pc_valid_o (next_pc_valid), .next_pc_o (next_pc)
    );

endmodule

/* logic/decoder.sv */
`timescale 1ns/1ps

module decoder import core_pkg::*; (
    input  logic [XLEN-1:0]       instr_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [XLEN-1:0]       imm_o,
    output alu_op_e               alu_op_o,
    output logic                  use_imm_o,
    output logic                  reg_write_o,
    output logic                  is_branch_o,
    output logic                  branch_ne_o,
    output logic                  is_jal_o,
    output logic                  is_load_o,
    output logic                  is_store_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    alu_op_e         arith_op;
    logic            arith_ok;
    logic            op_funct7_ok;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd_o   = instr_i[11:7];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // funct3 to alu operation, shared by register and immediate forms
    always_comb begin
        arith_ok = 1'b1;
        case (funct3)
            F3_ADD_SUB: arith_op = ALU_ADD;
            F3_SLT:     arith_op = ALU_SLT;
            F3_XOR:     arith_op = ALU_XOR;
            F3_OR:      arith_op = ALU_OR;
            F3_AND:     arith_op = ALU_AND;
            default: begin
                arith_op = ALU_ADD;
                arith_ok = 1'b0;
            end
        endcase
    end

    // only SUB may carry the alternate funct7
    assign op_funct7_ok = (funct7 == F7_BASE) || (funct7 == F7_SUB && funct3 == F3_ADD_SUB);

    always_comb begin
        // anything not matched below retires as a no-op
        imm_o       = imm_i;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        reg_write_o = 1'b0;
        is_branch_o = 1'b0;
        branch_ne_o = 1'b0;
        is_jal_o    = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        case (opcode)
            OPC_LUI: begin
                imm_o       = imm_u;
                alu_op_o    = ALU_PASS_B;
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op_o    = arith_op;
                use_imm_o   = arith_ok;
                reg_write_o = arith_ok;
            end
            OPC_OP: begin
                if (arith_ok && op_funct7_ok) begin
                    alu_op_o    = (funct7 == F7_SUB) ? ALU_SUB : arith_op;
                    reg_write_o = 1'b1;
                end
            end
            OPC_BRANCH: begin
                imm_o       = imm_b;
                alu_op_o    = ALU_SUB;
                is_branch_o = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                branch_ne_o = (funct3 == F3_BNE);
            end
            OPC_JAL: begin
                imm_o       = imm_j;
                reg_write_o = 1'b1;
                is_jal_o    = 1'b1;
            end
            OPC_LOAD: begin
                use_imm_o   = (funct3 == F3_LW);
                reg_write_o = (funct3 == F3_LW);
                is_load_o   = (funct3 == F3_LW);
            end
            OPC_STORE: begin
                imm_o      = imm_s;
                use_imm_o  = (funct3 == F3_SW);
                is_store_o = (funct3 == F3_SW);
            end
            default: ;
        endcase
    end

endmodule

/* logic/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  instr_valid_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  reg_write_i,
    input  logic                  is_branch_i,
    input  logic                  branch_ne_i,
    input  logic                  is_jal_i,
    input  logic                  is_load_i,
    input  logic                  is_store_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [XLEN-1:0]       alu_result_i,
    input  logic                  alu_equal_i,
    output logic                  dmem_req_valid_o,
    output logic [XLEN-1:0]       dmem_req_addr_o,
    output logic [XLEN-1:0]       dmem_req_wdata_o,
    output logic                  dmem_req_write_o,
    input  logic                  dmem_req_ready_i,
    input  logic                  dmem_resp_valid_i,
    input  logic [XLEN-1:0]       dmem_resp_data_i,
    output logic                  dmem_resp_ready_o,
    output logic                  rf_we_o,
    output logic [REG_ADDR_W-1:0] rf_rd_o,
    output logic [XLEN-1:0]       rf_wdata_o,
    output logic                  next_pc_valid_o,
    output logic [XLEN-1:0]       next_pc_o
);

    core_state_e     state_q;
    logic [XLEN-1:0] load_data_q;
    logic [XLEN-1:0] pc_plus4;
    logic            branch_taken;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= ST_FETCH;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    if (instr_valid_i) begin
                        state_q <= (is_load_i || is_store_i) ? ST_MEM_REQ : ST_EXEC;
                    end
                end
                ST_MEM_REQ: begin
                    // a store is done once accepted, a load waits for data
                    if (dmem_req_ready_i) begin
                        state_q <= is_store_i ? ST_EXEC : ST_MEM_RESP;
                    end
                end
                ST_MEM_RESP: begin
                    if (dmem_resp_valid_i) begin
                        state_q <= ST_EXEC;
                    end
                end
                default: state_q <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_MEM_RESP && dmem_resp_valid_i) begin
            load_data_q <= dmem_resp_data_i;
        end
    end

    // address is the alu sum, operands stay fixed while the instruction is held
    assign dmem_req_valid_o  = (state_q == ST_MEM_REQ);
    assign dmem_req_addr_o   = alu_result_i;
    assign dmem_req_wdata_o  = rs2_data_i;
    assign dmem_req_write_o  = is_store_i;
    assign dmem_resp_ready_o = (state_q == ST_MEM_RESP);

    assign pc_plus4     = pc_i + PC_STEP;
    assign branch_taken = is_branch_i && (branch_ne_i ? !alu_equal_i : alu_equal_i);

    // retire, writeback and next pc all happen in ST_EXEC
    assign rf_we_o    = (state_q == ST_EXEC) && reg_write_i;
    assign rf_rd_o    = rd_i;
    assign rf_wdata_o = is_jal_i ? pc_plus4 : (is_load_i ? load_data_q : alu_result_i);

    assign next_pc_valid_o = (state_q == ST_EXEC);
    assign next_pc_o       = (branch_taken || is_jal_i) ? pc_i + imm_i : pc_plus4;

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    output logic            imem_req_valid_o,
    output logic [XLEN-1:0] imem_req_addr_o,
    input  logic            imem_req_ready_i,
    input  logic            imem_resp_valid_i,
    input  logic [XLEN-1:0] imem_resp_data_i,
    output logic            imem_resp_ready_o,
    input  logic            next_pc_valid_i,
    input  logic [XLEN-1:0] next_pc_i,
    output logic            instr_valid_o,
    output logic [XLEN-1:0] instr_o,
    output logic [XLEN-1:0] pc_o
);

    typedef enum logic [1:0] {
        F_IDLE, F_REQ, F_WAIT, F_HOLD
    } fetch_state_e;

    fetch_state_e    state_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] instr_q;
    logic            instr_valid_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q       <= F_IDLE;
            pc_q          <= RESET_PC;
            instr_valid_q <= 1'b0;
        end else begin
            // one cycle pulse toward the execute unit
            instr_valid_q <= 1'b0;
            case (state_q)
                F_IDLE: state_q <= F_REQ;
                F_REQ: begin
                    if (imem_req_ready_i) begin
                        state_q <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    if (imem_resp_valid_i) begin
                        instr_valid_q <= 1'b1;
                        state_q       <= F_HOLD;
                    end
                end
                default: begin
                    // instruction stays put until it retires
                    if (next_pc_valid_i) begin
                        pc_q    <= next_pc_i;
                        state_q <= F_REQ;
                    end
                end
            endcase
        end
    end

    // instruction word, captured on the response handshake
    always_ff @(posedge clk_i) begin
        if (state_q == F_WAIT && imem_resp_valid_i) begin
            instr_q <= imem_resp_data_i;
        end
    end

    assign imem_req_valid_o  = (state_q == F_REQ);
    assign imem_req_addr_o   = pc_q;
    assign imem_resp_ready_o = (state_q == F_WAIT);
    assign instr_valid_o     = instr_valid_q;
    assign instr_o           = instr_q;
    assign pc_o              = pc_q;

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  we_i,
    input  logic [XLEN-1:0]       wdata_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // asynchronous reads
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator, verdict taken from sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core -f tb.f -o sim_tb_core \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb_core > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

/* tb.f */
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/register_file.sv
logic/alu.sv
logic/execute_unit.sv
logic/core_top.sv
verif/tb_clock_gen.sv
verif/tb_core_assertions.sv
verif/tb_core.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rstn_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

/* verif/tb_core.sv */
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

    localparam int          PROG_LEN    = 48;
    localparam int          DATA_WORDS  = 16;
    localparam int          STALL_LIMIT = 200;
    localparam logic [31:0] RESET_PC    = 32'h200;
    localparam logic [31:0] DATA_BASE   = 32'h100;
    localparam logic [31:0] LOOP_ADDR   = RESET_PC + 32'(4 * (PROG_LEN - 1));

    logic        clk;
    logic        rstn;
    logic        imem_req_valid_o;
    logic [31:0] imem_req_addr_o;
    logic        imem_req_ready_i;
    logic        imem_resp_valid_i;
    logic [31:0] imem_resp_data_i;
    logic        imem_resp_ready_o;
    logic        dmem_req_valid_o;
    logic [31:0] dmem_req_addr_o;
    logic [31:0] dmem_req_wdata_o;
    logic        dmem_req_write_o;
    logic        dmem_req_ready_i;
    logic        dmem_resp_valid_i;
    logic [31:0] dmem_resp_data_i;
    logic        dmem_resp_ready_o;

    // program, memory model contents and reference state
    logic [31:0] prog [PROG_LEN];
    logic [31:0] dmem [DATA_WORDS];
    logic [31:0] ref_mem [DATA_WORDS];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] rng_state;

    // expected data access of the instruction in flight
    logic        exp_d_valid;
    logic [31:0] exp_d_addr;
    logic        exp_d_write;
    logic [31:0] exp_d_wdata;

    // memory model response state
    logic        ibusy;
    int          iaddr;
    int          idelay;
    logic        dbusy;
    int          daddr;
    int          ddelay;
    int          loop_fetches;
    int          since_fetch;

    tb_clock_gen #(.RESET_CYCLES(3)) u_clock (.clk_o(clk), .rstn_o(rstn));

    core_top #(.RESET_PC(RESET_PC)) uut (
        .clk_i (clk), .rstn_i (rstn),
        .imem_req_valid_o, .imem_req_addr_o, .imem_req_ready_i,
        .imem_resp_valid_i, .imem_resp_data_i, .imem_resp_ready_o,
        .dmem_req_valid_o, .dmem_req_addr_o, .dmem_req_wdata_o, .dmem_req_write_o,
        .dmem_req_ready_i, .dmem_resp_valid_i, .dmem_resp_data_i, .dmem_resp_ready_o
    );

    bind core_top tb_core_assertions u_assertions (
        .clk_i, .rstn_i,
        .imem_req_valid_i (imem_req_valid_o), .imem_req_addr_i (imem_req_addr_o),
        .imem_req_ready_i, .imem_resp_ready_i (imem_resp_ready_o),
        .dmem_req_valid_i (dmem_req_valid_o), .dmem_req_addr_i (dmem_req_addr_o),
        .dmem_req_wdata_i (dmem_req_wdata_o), .dmem_req_write_i (dmem_req_write_o),
        .dmem_req_ready_i, .dmem_resp_ready_i (dmem_resp_ready_o)
    );

    // lcg with the numerical recipes constants
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int unsigned below(int unsigned n);
        return (next_rand() >> 8) % n;
    endfunction

    // x1 to x7 only
    function automatic logic [4:0] rand_reg();
        return 5'(1 + below(7));
    endfunction

    function automatic logic [2:0] rand_arith_f3();
        logic [2:0] codes [5];
        codes = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        return codes[below(5)];
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic int widx(logic [31:0] addr);
        return int'(((addr - DATA_BASE) >> 2) & 32'd15);
    endfunction

    // reference alu taken from the ISA definition
    function automatic logic [31:0] arith(logic [2:0] f3, logic sub, logic [31:0] a,
                                          logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a;
        endcase
    endfunction

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            stop_with_failure($sformatf("ERROR at %0t: %s expected %h, got %h",
                                        $time, name, exp, act));
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] off;
        int          t;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r   = next_rand();
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            f3  = rand_arith_f3();
            off = 12'(DATA_BASE + 4 * below(DATA_WORDS));
            // forward target clipped to the final self loop
            t = i + 1 + int'(below(4));
            if (t > PROG_LEN - 1) begin
                t = PROG_LEN - 1;
            end
            case (below(8))
                0: prog[i] = {r[31:12], rd, OPC_LUI};
                1: prog[i] = enc_i(r[11:0], rs1, f3, rd, OPC_OP_IMM);
                2: prog[i] = {(f3 == 3'b000 && r[0]) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd,
                              OPC_OP};
                3: prog[i] = enc_i(off, 5'd0, 3'b010, rd, OPC_LOAD);
                4: prog[i] = enc_s(off, rs2, 5'd0);
                5: prog[i] = enc_b(13'(4 * (t - i)), rs2, rs1, {2'b00, r[0]});
                6: prog[i] = enc_j(21'(4 * (t - i)), rd);
                // slli is outside the subset and must act as a no-op
                default: prog[i] = enc_i({7'b0, r[4:0]}, rs1, 3'b001, rd, OPC_OP_IMM);
            endcase
        end
        prog[PROG_LEN-1] = enc_j(21'd0, 5'd0);
    endtask

    task automatic write_reg(logic [4:0] rd, logic [31:0] val);
        if (rd != 5'd0) begin
            ref_regs[rd] = val;
        end
    endtask

    // executes the instruction at ref_pc in the reference model
    task automatic execute_model();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nxt;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [2:0]  f3;
        ins   = prog[int'((ref_pc - RESET_PC) >> 2)];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        f3    = ins[14:12];
        nxt   = ref_pc + 32'd4;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        case (ins[6:0])
            OPC_LUI: write_reg(ins[11:7], {ins[31:12], 12'b0});
            OPC_OP_IMM: begin
                if (f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) begin
                    write_reg(ins[11:7], arith(f3, 1'b0, a, imm_i));
                end
            end
            OPC_OP: write_reg(ins[11:7], arith(f3, ins[30], a, b));
            OPC_BRANCH: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                    nxt = ref_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                write_reg(ins[11:7], ref_pc + 32'd4);
                nxt = ref_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_LOAD: begin
                exp_d_valid = 1'b1;
                exp_d_addr  = a + imm_i;
                exp_d_write = 1'b0;
                write_reg(ins[11:7], ref_mem[widx(a + imm_i)]);
            end
            OPC_STORE: begin
                exp_d_valid = 1'b1;
                exp_d_addr  = a + imm_s;
                exp_d_write = 1'b1;
                exp_d_wdata = b;
                ref_mem[widx(a + imm_s)] = b;
            end
            default: ;
        endcase
        ref_pc = nxt;
    endtask

    // handshakes are sampled on the rising edge
    always @(posedge clk) begin
        if (rstn) begin
            since_fetch++;
            if (imem_resp_valid_i && imem_resp_ready_o) begin
                ibusy = 1'b0;
            end
            if (imem_req_valid_o && imem_req_ready_i) begin
                if (exp_d_valid) begin
                    stop_with_failure("next fetch began before the data access of a load or store");
                end
                check_value("imem_req_addr_o", ref_pc, imem_req_addr_o);
                if (imem_req_addr_o == LOOP_ADDR) begin
                    loop_fetches++;
                end
                since_fetch = 0;
                execute_model();
                ibusy  = 1'b1;
                iaddr  = int'((imem_req_addr_o - RESET_PC) >> 2);
                idelay = int'(below(6));
            end
            if (dmem_resp_valid_i && dmem_resp_ready_o) begin
                dbusy = 1'b0;
            end
            if (dmem_req_valid_o && dmem_req_ready_i) begin
                if (!exp_d_valid) begin
                    stop_with_failure("data request seen for an instruction without memory access");
                end
                check_value("dmem_req_addr_o", exp_d_addr, dmem_req_addr_o);
                check_value("dmem_req_write_o", 32'(exp_d_write), 32'(dmem_req_write_o));
                if (exp_d_write) begin
                    check_value("dmem_req_wdata_o", exp_d_wdata, dmem_req_wdata_o);
                    dmem[widx(dmem_req_addr_o)] = dmem_req_wdata_o;
                end else begin
                    dbusy  = 1'b1;
                    daddr  = widx(dmem_req_addr_o);
                    ddelay = int'(below(6));
                end
                exp_d_valid = 1'b0;
            end
        end
    end

    // memory models drive on the falling edge
    always @(negedge clk) begin
        imem_req_ready_i  <= (below(4) != 0);
        dmem_req_ready_i  <= (below(4) != 0);
        imem_resp_valid_i <= 1'b0;
        dmem_resp_valid_i <= 1'b0;
        if (ibusy) begin
            if (idelay > 0) begin
                idelay--;
            end else begin
                imem_resp_valid_i <= 1'b1;
                imem_resp_data_i  <= (iaddr < PROG_LEN) ? prog[iaddr] : 32'h0;
            end
        end
        if (dbusy) begin
            if (ddelay > 0) begin
                ddelay--;
            end else begin
                dmem_resp_valid_i <= 1'b1;
                dmem_resp_data_i  <= dmem[daddr];
            end
        end
    end

    initial begin
        int n;
        rng_state         = 32'd27;
        imem_req_ready_i  = 1'b0;
        imem_resp_valid_i = 1'b0;
        imem_resp_data_i  = 32'h0;
        dmem_req_ready_i  = 1'b0;
        dmem_resp_valid_i = 1'b0;
        dmem_resp_data_i  = 32'h0;
        exp_d_valid       = 1'b0;
        exp_d_addr        = 32'h0;
        exp_d_write       = 1'b0;
        exp_d_wdata       = 32'h0;
        ibusy             = 1'b0;
        dbusy             = 1'b0;
        iaddr             = 0;
        daddr             = 0;
        idelay            = 0;
        ddelay            = 0;
        loop_fetches      = 0;
        since_fetch       = 0;
        ref_pc            = RESET_PC;
        for (int k = 0; k < 32; k++) begin
            ref_regs[k] = 32'h0;
        end
        build_program();
        for (int k = 0; k < DATA_WORDS; k++) begin
            dmem[k]    = next_rand();
            ref_mem[k] = dmem[k];
        end
        n = 0;
        while (!rstn && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!rstn) begin
            stop_with_failure("reset was never released");
        end
        while (loop_fetches < 2 && since_fetch < STALL_LIMIT) begin
            @(negedge clk);
        end
        if (loop_fetches >= 2) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("core stalled, no instruction fetch for %0d cycles",
                                        STALL_LIMIT));
        end
    end

endmodule

/* verif/tb_core_assertions.sv */
`timescale 1ns/1ps

module tb_core_assertions import core_pkg::*; (
    input logic            clk_i,
    input logic            rstn_i,
    input logic            imem_req_valid_i,
    input logic [XLEN-1:0] imem_req_addr_i,
    input logic            imem_req_ready_i,
    input logic            imem_resp_ready_i,
    input logic            dmem_req_valid_i,
    input logic [XLEN-1:0] dmem_req_addr_i,
    input logic [XLEN-1:0] dmem_req_wdata_i,
    input logic            dmem_req_write_i,
    input logic            dmem_req_ready_i,
    input logic            dmem_resp_ready_i
);

    // a pending instruction request keeps its address
    imem_req_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        imem_req_valid_i && !imem_req_ready_i |=> imem_req_valid_i && $stable(imem_req_addr_i))
        else $error("instruction request dropped or changed before acceptance");

    // a pending data request keeps address, data and direction
    dmem_req_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dmem_req_valid_i && !dmem_req_ready_i |=> dmem_req_valid_i
            && $stable(dmem_req_addr_i) && $stable(dmem_req_wdata_i)
            && $stable(dmem_req_write_i))
        else $error("data request dropped or changed before acceptance");

    // all handshake outputs quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk_i)
        !rstn_i |=> !(imem_req_valid_i || imem_resp_ready_i
            || dmem_req_valid_i || dmem_resp_ready_i))
        else $error("handshake output active during reset");

endmodule
